/* verilog/tofHistPkg.sv */
`default_nettype none

package tofHistPkg;

    localparam int TS_W = 10;
    localparam int BIN_W = 4;
    localparam int COUNT_W = 8;   // Saturating bin counters
    localparam int PIX_W = 2;     // Up to 4 pixels

    localparam int OFF_W = TS_W - BIN_W;
    localparam int NUM_BINS = 1 << BIN_W;   // Coarse bins, also fine window width
    localparam int HALF_WIN = NUM_BINS / 2;

    // Middle of a coarse bin
    localparam logic [OFF_W-1:0] MID_OFFSET = OFF_W'(1) << (OFF_W - 1);

    typedef struct packed {
        logic [BIN_W-1:0] coarseBin;
        logic [OFF_W-1:0] offset;
    } coarseView_t;

    // One TDC word, read raw by the fine path and split by the coarse path
    typedef union packed {
        logic [TS_W-1:0] raw;
        coarseView_t coarse;
    } tdcWord_u;

    typedef struct packed {
        tdcWord_u word;
        logic [PIX_W-1:0] pixel;
        logic frameLast;          // Final sample of the frame
    } taggedSample_t;

    typedef struct packed {
        logic [BIN_W-1:0] bin;
        logic [COUNT_W-1:0] count;
    } peak_t;

    typedef struct packed {
        logic [TS_W-1:0] base;
        logic valid;
    } window_t;

    typedef struct packed {
        logic [PIX_W-1:0] pixel;
        logic [TS_W-1:0] tofTime;
        logic fine;               // Set when the fine peak gave the time
    } result_t;

endpackage

`default_nettype wire

/* verilog/sampleIngress.sv */
`timescale 1ns/1ps
`default_nettype none

module sampleIngress #(
    parameter int PIXELS = 4,
    parameter int SAMPLES_PER_PIXEL = 8,
    parameter int ACQ_PER_FRAME = 2,
    parameter int IN_CREDITS = 4
) (
    input wire logic clk,
    input wire logic combin_res,
    input wire logic sampleValid,
    input wire tofHistPkg::tdcWord_u sampleData,
    output logic sampleCredit,
    input wire logic frameDone,
    output logic issueValid,
    output tofHistPkg::taggedSample_t issueSample
);

    localparam int PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
    localparam int CNT_W = $clog2(IN_CREDITS + 1);
    localparam int SMP_W = (SAMPLES_PER_PIXEL > 1) ? $clog2(SAMPLES_PER_PIXEL) : 1;
    localparam int ACQ_W = (ACQ_PER_FRAME > 1) ? $clog2(ACQ_PER_FRAME) : 1;

    tofHistPkg::tdcWord_u fifoMem [IN_CREDITS];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] fifoCount;
    logic [CNT_W-1:0] initCount;   // Startup credits handed out so far
    logic initDone;
    logic issueFire;
    logic halted;
    logic [SMP_W-1:0] sampleCnt;
    logic [tofHistPkg::PIX_W-1:0] pixelCnt;
    logic [ACQ_W-1:0] acqCnt;
    logic lastSample;
    logic lastPixel;
    logic lastAcq;
    logic frameEnd;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // No issue during the startup credits, so credit pulses never collide
    assign initDone = (initCount == CNT_W'(IN_CREDITS));
    assign issueFire = initDone && (fifoCount != '0) && !halted;

    assign lastSample = (sampleCnt == SMP_W'(SAMPLES_PER_PIXEL - 1));
    assign lastPixel = (pixelCnt == tofHistPkg::PIX_W'(PIXELS - 1));
    assign lastAcq = (acqCnt == ACQ_W'(ACQ_PER_FRAME - 1));
    assign frameEnd = lastSample && lastPixel && lastAcq;

    always_ff @(posedge clk) begin
        if (sampleValid)
            fifoMem[wrPtr] <= sampleData;
        if (issueFire) begin
            issueSample.word <= fifoMem[rdPtr];
            issueSample.pixel <= pixelCnt;
            issueSample.frameLast <= frameEnd;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fifoCount <= '0;
            initCount <= '0;
            sampleCredit <= 1'b0;
            issueValid <= 1'b0;
            halted <= 1'b0;
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
        end else begin
            if (!initDone)
                initCount <= initCount + 1'b1;
            sampleCredit <= !initDone || issueFire;   // Freed slot returns a credit
            issueValid <= issueFire;

            if (sampleValid)
                wrPtr <= nextPtr(wrPtr);
            if (issueFire)
                rdPtr <= nextPtr(rdPtr);
            fifoCount <= fifoCount + CNT_W'(sampleValid) - CNT_W'(issueFire);

            if (issueFire) begin
                sampleCnt <= lastSample ? '0 : sampleCnt + 1'b1;
                if (lastSample) begin
                    pixelCnt <= lastPixel ? '0 : pixelCnt + 1'b1;
                    if (lastPixel)
                        acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                end
            end

            // Hold off the next frame until the combiner is finished
            if (issueFire && frameEnd)
                halted <= 1'b1;
            else if (frameDone)
                halted <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/coarseHistogram.sv */
`timescale 1ns/1ps
`default_nettype none

module coarseHistogram #(
    parameter int PIXELS = 4
) (
    input wire logic clk,
    input wire logic combin_res,
    input wire logic issueValid,
    input wire tofHistPkg::taggedSample_t issueSample,
    output tofHistPkg::peak_t [PIXELS-1:0] peaks,
    output logic peaksReady
);

    localparam int RAM_DEPTH = PIXELS * tofHistPkg::NUM_BINS;
    localparam int ADDR_W = tofHistPkg::PIX_W + tofHistPkg::BIN_W;

    logic [tofHistPkg::COUNT_W-1:0] binRam [RAM_DEPTH];
    logic [RAM_DEPTH-1:0] binValid;   // Cleared bins read as zero
    logic [ADDR_W-1:0] wrAddr;
    logic [tofHistPkg::COUNT_W-1:0] oldCount;
    logic [tofHistPkg::COUNT_W-1:0] newCount;

    logic updValid;
    logic updLast;
    logic [tofHistPkg::PIX_W-1:0] updPixel;
    logic [tofHistPkg::BIN_W-1:0] updBin;
    logic [tofHistPkg::COUNT_W-1:0] updCount;

    // Pixel selects the histogram, top timestamp bits select the bin
    assign wrAddr = {issueSample.pixel, issueSample.word.coarse.coarseBin};
    assign oldCount = binValid[wrAddr] ? binRam[wrAddr] : '0;
    assign newCount = (oldCount == '1) ? oldCount : oldCount + 1'b1;

    always_ff @(posedge clk) begin
        if (issueValid)
            binRam[wrAddr] <= newCount;
        updPixel <= issueSample.pixel;
        updBin <= issueSample.word.coarse.coarseBin;
        updCount <= newCount;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            updValid <= 1'b0;
            updLast <= 1'b0;
            peaksReady <= 1'b0;
            peaks <= '0;
        end else begin
            updValid <= issueValid;
            updLast <= issueValid && issueSample.frameLast;
            peaksReady <= updLast;

            if (peaksReady)
                binValid <= '0;
            else if (issueValid)
                binValid[wrAddr] <= 1'b1;

            for (int p = 0; p < PIXELS; p++) begin
                if (peaksReady)
                    peaks[p] <= '0;
                else if (updValid && updPixel == tofHistPkg::PIX_W'(p)
                         && updCount > peaks[p].count) begin
                    peaks[p].bin <= updBin;   // Strictly greater, earliest bin wins
                    peaks[p].count <= updCount;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fineHistogram.sv */
`timescale 1ns/1ps
`default_nettype none

module fineHistogram #(
    parameter int PIXELS = 4
) (
    input wire logic clk,
    input wire logic combin_res,
    input wire logic issueValid,
    input wire tofHistPkg::taggedSample_t issueSample,
    input wire tofHistPkg::window_t [PIXELS-1:0] windows,
    output tofHistPkg::peak_t [PIXELS-1:0] peaks,
    output logic peaksReady
);

    localparam int RAM_DEPTH = PIXELS * tofHistPkg::NUM_BINS;
    localparam int ADDR_W = tofHistPkg::PIX_W + tofHistPkg::BIN_W;

    logic [tofHistPkg::COUNT_W-1:0] binRam [RAM_DEPTH];
    logic [RAM_DEPTH-1:0] binValid;
    tofHistPkg::window_t curWin;
    logic [tofHistPkg::TS_W-1:0] tsOffset;
    logic inWindow;
    logic countEn;
    logic [ADDR_W-1:0] wrAddr;
    logic [tofHistPkg::COUNT_W-1:0] oldCount;
    logic [tofHistPkg::COUNT_W-1:0] newCount;

    logic updValid;
    logic updLast;
    logic [tofHistPkg::PIX_W-1:0] updPixel;
    logic [tofHistPkg::BIN_W-1:0] updBin;
    logic [tofHistPkg::COUNT_W-1:0] updCount;

    assign curWin = windows[issueSample.pixel];
    assign tsOffset = issueSample.word.raw - curWin.base;

    // Window never crosses the range ends, so two compares are enough
    assign inWindow = curWin.valid
                   && (issueSample.word.raw >= curWin.base)
                   && (tsOffset < tofHistPkg::TS_W'(tofHistPkg::NUM_BINS));
    assign countEn = issueValid && inWindow;

    assign wrAddr = {issueSample.pixel, tsOffset[tofHistPkg::BIN_W-1:0]};
    assign oldCount = binValid[wrAddr] ? binRam[wrAddr] : '0;
    assign newCount = (oldCount == '1) ? oldCount : oldCount + 1'b1;

    always_ff @(posedge clk) begin
        if (countEn)
            binRam[wrAddr] <= newCount;
        updPixel <= issueSample.pixel;
        updBin <= tsOffset[tofHistPkg::BIN_W-1:0];
        updCount <= newCount;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            updValid <= 1'b0;
            updLast <= 1'b0;
            peaksReady <= 1'b0;
            peaks <= '0;
        end else begin
            updValid <= countEn;
            // Frame end is tracked even when the last sample misses the window
            updLast <= issueValid && issueSample.frameLast;
            peaksReady <= updLast;

            if (peaksReady)
                binValid <= '0;
            else if (countEn)
                binValid[wrAddr] <= 1'b1;

            for (int p = 0; p < PIXELS; p++) begin
                if (peaksReady)
                    peaks[p] <= '0;
                else if (updValid && updPixel == tofHistPkg::PIX_W'(p)
                         && updCount > peaks[p].count) begin
                    peaks[p].bin <= updBin;
                    peaks[p].count <= updCount;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/peakCombiner.sv */
`timescale 1ns/1ps
`default_nettype none

module peakCombiner #(
    parameter int PIXELS = 4,
    parameter int OUT_CREDITS = 2
) (
    input wire logic clk,
    input wire logic combin_res,
    input wire tofHistPkg::peak_t [PIXELS-1:0] coarsePeaks,
    input wire tofHistPkg::peak_t [PIXELS-1:0] finePeaks,
    input wire logic peaksReady,
    output tofHistPkg::window_t [PIXELS-1:0] windows,
    output logic resultValid,
    output tofHistPkg::result_t result,
    input wire logic resultCredit,
    output logic frameDone
);

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WRAP
    } state_t;

    state_t state;
    tofHistPkg::peak_t [PIXELS-1:0] coarseHeld;
    tofHistPkg::peak_t [PIXELS-1:0] fineHeld;
    tofHistPkg::window_t [PIXELS-1:0] nextWindows;
    tofHistPkg::result_t nextResult;
    logic [tofHistPkg::PIX_W-1:0] sendPixel;
    logic [CRED_W-1:0] credits;
    logic sendOk;
    logic lastPixel;

    // Centre of a coarse bin built through the split view of the word
    function automatic logic [tofHistPkg::TS_W-1:0] centreOf(
        input logic [tofHistPkg::BIN_W-1:0] bin
    );
        tofHistPkg::tdcWord_u centre;
        centre.coarse.coarseBin = bin;
        centre.coarse.offset = tofHistPkg::MID_OFFSET;
        return centre.raw;
    endfunction

    assign sendOk = (state == SEND) && (credits != '0);
    assign lastPixel = (sendPixel == tofHistPkg::PIX_W'(PIXELS - 1));

    // Windows still hold this frame's placement while results go out
    always_comb begin
        nextResult.pixel = sendPixel;
        if (windows[sendPixel].valid && fineHeld[sendPixel].count != '0) begin
            nextResult.tofTime = windows[sendPixel].base
                               + tofHistPkg::TS_W'(fineHeld[sendPixel].bin);
            nextResult.fine = 1'b1;
        end else begin
            nextResult.tofTime = centreOf(coarseHeld[sendPixel].bin);
            nextResult.fine = 1'b0;
        end
    end

    always_comb begin
        for (int p = 0; p < PIXELS; p++) begin
            nextWindows[p].base = centreOf(coarseHeld[p].bin)
                                - tofHistPkg::TS_W'(tofHistPkg::HALF_WIN);
            nextWindows[p].valid = (coarseHeld[p].count != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (peaksReady) begin
            coarseHeld <= coarsePeaks;
            fineHeld <= finePeaks;
        end
        if (sendOk)
            result <= nextResult;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= IDLE;
            sendPixel <= '0;
            credits <= CRED_W'(OUT_CREDITS);
            resultValid <= 1'b0;
            frameDone <= 1'b0;
            windows <= '0;
        end else begin
            resultValid <= sendOk;
            frameDone <= 1'b0;
            credits <= credits - CRED_W'(sendOk) + CRED_W'(resultCredit);

            case (state)
                IDLE: begin
                    if (peaksReady) begin
                        state <= SEND;
                        sendPixel <= '0;
                    end
                end
                SEND: begin
                    if (sendOk) begin   // Stalls here while out of credits
                        if (lastPixel)
                            state <= WRAP;
                        else
                            sendPixel <= sendPixel + 1'b1;
                    end
                end
                WRAP: begin
                    windows <= nextWindows;   // Placement for the next frame
                    frameDone <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/tofHistogramTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tofHistogramTop #(
    parameter int PIXELS = 4,
    parameter int SAMPLES_PER_PIXEL = 8,
    parameter int ACQ_PER_FRAME = 2,
    parameter int IN_CREDITS = 4,
    parameter int OUT_CREDITS = 2
) (
    input wire logic clk,
    input wire logic combin_res,
    input wire logic sampleValid,
    input wire tofHistPkg::tdcWord_u sampleData,
    output logic sampleCredit,
    output logic resultValid,
    output tofHistPkg::result_t result,
    input wire logic resultCredit
);

    logic issueValid;
    tofHistPkg::taggedSample_t issueSample;
    tofHistPkg::peak_t [PIXELS-1:0] coarsePeaks;
    tofHistPkg::peak_t [PIXELS-1:0] finePeaks;
    logic fineReady;
    tofHistPkg::window_t [PIXELS-1:0] windows;
    logic frameDone;

    sampleIngress #(
        .PIXELS(PIXELS),
        .SAMPLES_PER_PIXEL(SAMPLES_PER_PIXEL),
        .ACQ_PER_FRAME(ACQ_PER_FRAME),
        .IN_CREDITS(IN_CREDITS)
    ) uIngress (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .sampleData(sampleData),
        .sampleCredit(sampleCredit),
        .frameDone(frameDone),
        .issueValid(issueValid),
        .issueSample(issueSample)
    );

    // Both histograms pulse together, the combiner follows the fine one
    coarseHistogram #(.PIXELS(PIXELS)) uCoarse (
        .clk(clk),
        .combin_res(combin_res),
        .issueValid(issueValid),
        .issueSample(issueSample),
        .peaks(coarsePeaks),
        .peaksReady()
    );

    fineHistogram #(.PIXELS(PIXELS)) uFine (
        .clk(clk),
        .combin_res(combin_res),
        .issueValid(issueValid),
        .issueSample(issueSample),
        .windows(windows),
        .peaks(finePeaks),
        .peaksReady(fineReady)
    );

    peakCombiner #(
        .PIXELS(PIXELS),
        .OUT_CREDITS(OUT_CREDITS)
    ) uCombiner (
        .clk(clk),
        .combin_res(combin_res),
        .coarsePeaks(coarsePeaks),
        .finePeaks(finePeaks),
        .peaksReady(fineReady),
        .windows(windows),
        .resultValid(resultValid),
        .result(result),
        .resultCredit(resultCredit),
        .frameDone(frameDone)
    );

endmodule

`default_nettype wire

/* verif/tofHistogram_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tofHistogramChecker #(
    parameter int IN_CREDITS = 4,
    parameter int OUT_CREDITS = 2
) (
    input wire logic clk,
    input wire logic combin_res,
    input wire logic sampleValid,
    input wire logic sampleCredit,
    input wire logic issueValid,
    input wire logic frameDone,
    input wire logic resultValid,
    input wire logic resultCredit
);

    int inHeld;       // Credits held by the source
    int fifoLevel;    // Seen through issue, so one cycle late on the read side
    int resultsOut;   // Results not yet credited back

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            inHeld <= 0;
            fifoLevel <= 0;
            resultsOut <= 0;
        end else begin
            inHeld <= inHeld + int'(sampleCredit) - int'(sampleValid);
            fifoLevel <= fifoLevel + int'(sampleValid) - int'(issueValid);
            resultsOut <= resultsOut + int'(resultValid) - int'(resultCredit);
        end
    end

    assert property (@(posedge clk) disable iff (!combin_res) inHeld <= IN_CREDITS)
        else $error("More input credits handed out than FIFO slots");

    assert property (@(posedge clk) disable iff (!combin_res)
        fifoLevel >= 0 && fifoLevel <= IN_CREDITS)
        else $error("FIFO level out of bounds");

    assert property (@(posedge clk) disable iff (!combin_res) resultsOut <= OUT_CREDITS)
        else $error("Results sent beyond the output credits");

    assert property (@(posedge clk)
        (!combin_res && $past(!combin_res))
            |-> !(sampleCredit || issueValid || resultValid || frameDone))
        else $error("Strobe active during reset");

endmodule

bind tofHistogramTop tofHistogramChecker #(
    .IN_CREDITS(IN_CREDITS),
    .OUT_CREDITS(OUT_CREDITS)
) uChecker (
    .clk(clk),
    .combin_res(combin_res),
    .sampleValid(sampleValid),
    .sampleCredit(sampleCredit),
    .issueValid(issueValid),
    .frameDone(frameDone),
    .resultValid(resultValid),
    .resultCredit(resultCredit)
);

`default_nettype wire

/* verif/tofHistogramTb.sv */
`timescale 1ns/1ps
`default_nettype none

module tofHistogramTb;

    localparam int PIXELS = 4;
    localparam int SAMPLES_PER_PIXEL = 8;
    localparam int ACQ_PER_FRAME = 2;
    localparam int IN_CREDITS = 4;
    localparam int OUT_CREDITS = 2;
    localparam int FRAMES = 5;
    localparam int ROWS = FRAMES * PIXELS;
    localparam int PER_PIXEL = SAMPLES_PER_PIXEL * ACQ_PER_FRAME;   // Samples per pixel per frame
    localparam int STALL_CYCLES = 40;
    localparam int TIMEOUT_CYCLES = FRAMES * (PIXELS * 16 + PIXELS + 20) * 4;

    typedef struct packed {
        logic [9:0] peakTs;
        logic [4:0] hits;
        logic stall;          // Consumer holds its credits after this result
        logic [9:0] expTime;
        logic expFine;
    } stimRow_t;

    logic clk = 1'b0;
    logic combin_res;
    logic sampleValid;
    tofHistPkg::tdcWord_u sampleData;
    logic sampleCredit;
    logic resultValid;
    tofHistPkg::result_t result;
    logic resultCredit;

    stimRow_t stimRows [ROWS];
    logic [9:0] sampleQ [$];
    logic [31:0] rngState;
    int cycleCount = 0;
    int sourceCredits = 0;
    int creditsSeen = 0;       // All sampleCredit pulses since reset
    bit sourceEnable = 1'b0;
    int resultIdx = 0;
    int pendingCredits = 0;    // Results held by the consumer
    int stallUntil = 0;

    tofHistogramTop DUT (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .sampleData(sampleData),
        .sampleCredit(sampleCredit),
        .resultValid(resultValid),
        .result(result),
        .resultCredit(resultCredit)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkValue(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic setRow(input int frame, input int pixel, input int peakTs, input int hits,
                          input bit stall, input int expTime, input bit expFine);
        stimRows[frame * PIXELS + pixel] = {10'(peakTs), 5'(hits), stall, 10'(expTime), expFine};
    endtask

    // Coarse centre is bin*64+32, fine window is centre-8 up to centre+7
    task automatic fillTable();
        setRow(0, 0, 300, 12, 1'b0, 288, 1'b0);   // First frame has no window
        setRow(0, 1, 100, 16, 1'b0, 96, 1'b0);
        setRow(0, 2, 500, 16, 1'b0, 480, 1'b0);
        setRow(0, 3, 1010, 11, 1'b0, 992, 1'b0);
        setRow(1, 0, 290, 14, 1'b0, 290, 1'b1);
        setRow(1, 1, 101, 10, 1'b1, 101, 1'b1);
        setRow(1, 2, 700, 10, 1'b0, 672, 1'b0);   // Fewer hits on a new bin
        setRow(1, 3, 990, 16, 1'b0, 990, 1'b1);
        setRow(2, 0, 283, 10, 1'b0, 283, 1'b1);
        setRow(2, 1, 900, 13, 1'b0, 928, 1'b0);   // Window miss
        setRow(2, 2, 675, 12, 1'b0, 675, 1'b1);
        setRow(2, 3, 999, 10, 1'b1, 999, 1'b1);   // Top edge of the window
        setRow(3, 0, 600, 16, 1'b1, 608, 1'b0);   // Window miss
        setRow(3, 1, 935, 10, 1'b0, 935, 1'b1);
        setRow(3, 2, 670, 10, 1'b0, 670, 1'b1);
        setRow(3, 3, 984, 13, 1'b0, 984, 1'b1);   // Bottom edge of the window
        setRow(4, 0, 600, 11, 1'b0, 600, 1'b1);   // Recovered after the miss
        setRow(4, 1, 920, 15, 1'b0, 920, 1'b1);
        setRow(4, 2, 40, 14, 1'b0, 32, 1'b0);
        setRow(4, 3, 200, 10, 1'b0, 224, 1'b0);
    endtask

    task automatic buildSamples();
        logic [9:0] pixSamples [PIXELS][PER_PIXEL];
        logic [15:0] usedBins;
        logic [3:0] bin;
        logic [5:0] offset;
        stimRow_t row;
        for (int f = 0; f < FRAMES; f++) begin
            for (int p = 0; p < PIXELS; p++) begin
                row = stimRows[f * PIXELS + p];
                usedBins = '0;
                usedBins[row.peakTs[9:6]] = 1'b1;
                for (int s = 0; s < PER_PIXEL; s++) begin
                    if (s >= PER_PIXEL - int'(row.hits)) begin
                        pixSamples[p][s] = row.peakTs;
                    end else begin
                        // One noise hit per free coarse bin, never inside a window offset
                        do begin
                            rngState = xorshift(rngState);
                            bin = rngState[3:0];
                        end while (usedBins[bin]);
                        usedBins[bin] = 1'b1;
                        offset = rngState[8] ? 6'd48 + 6'(rngState[7:4]) : 6'(rngState[7:4]);
                        pixSamples[p][s] = {bin, offset};
                    end
                end
            end
            for (int a = 0; a < ACQ_PER_FRAME; a++)
                for (int p = 0; p < PIXELS; p++)
                    for (int s = 0; s < SAMPLES_PER_PIXEL; s++)
                        sampleQ.push_back(pixSamples[p][a * SAMPLES_PER_PIXEL + s]);
        end
    endtask

    task automatic checkResult();
        stimRow_t row;
        int frame;
        checkValue("extra result after the last frame", int'(resultIdx < ROWS), 1);
        row = stimRows[resultIdx];
        frame = resultIdx / PIXELS;
        checkValue($sformatf("frame %0d result pixel", frame), int'(result.pixel),
                   resultIdx % PIXELS);
        checkValue($sformatf("frame %0d pixel %0d time", frame, resultIdx % PIXELS),
                   int'(result.tofTime), int'(row.expTime));
        checkValue($sformatf("frame %0d pixel %0d fine flag", frame, resultIdx % PIXELS),
                   int'(result.fine), int'(row.expFine));
        pendingCredits++;
        checkValue("results outstanding within credits", int'(pendingCredits <= OUT_CREDITS), 1);
        if (row.stall)
            stallUntil = cycleCount + STALL_CYCLES;
        resultIdx++;
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout: %0d of %0d results after %0d cycles", resultIdx, ROWS, cycleCount);
            $display("sim failed");
            $fatal(1, "run did not finish");
        end
    end

    // TDC source model
    always @(posedge clk) begin
        #2;
        if (!combin_res) begin
            checkValue("sampleCredit during reset", int'(sampleCredit), 0);
        end else begin
            if (sampleCredit) begin
                sourceCredits++;
                creditsSeen++;
            end
            checkValue("credits held by the source", int'(sourceCredits <= IN_CREDITS), 1);
            if (sourceEnable && sourceCredits > 0 && sampleQ.size() > 0) begin
                sampleValid = 1'b1;
                sampleData.raw = sampleQ.pop_front();
                sourceCredits--;
            end else begin
                sampleValid = 1'b0;
            end
        end
    end

    // Result consumer returning one credit per cycle unless stalled
    always @(posedge clk) begin
        #2;
        resultCredit = 1'b0;
        if (!combin_res) begin
            checkValue("resultValid during reset", int'(resultValid), 0);
        end else begin
            if (resultValid)
                checkResult();
            if (pendingCredits > 0 && cycleCount >= stallUntil) begin
                resultCredit = 1'b1;
                pendingCredits--;
            end
        end
    end

    initial begin
        combin_res = 1'b0;
        sampleValid = 1'b0;
        sampleData = '0;
        resultCredit = 1'b0;
        rngState = 32'h1c8;
        fillTable();
        buildSamples();
        repeat (10) @(posedge clk);
        #2 combin_res = 1'b1;
        repeat (2 * IN_CREDITS + 4) @(posedge clk);
        checkValue("startup credits before any sample", creditsSeen, IN_CREDITS);
        sourceEnable = 1'b1;
        wait (resultIdx == ROWS);
        repeat (10) @(posedge clk);
        checkValue("samples never sent", sampleQ.size(), 0);
        checkValue("sample credits returned", creditsSeen,
                   IN_CREDITS + FRAMES * PIXELS * PER_PIXEL);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/tofHistPkg.sv
verilog/sampleIngress.sv
verilog/coarseHistogram.sv
verilog/fineHistogram.sv
verilog/peakCombiner.sv
verilog/tofHistogramTop.sv
verif/tofHistogram_checker.sv
verif/tofHistogramTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module tofHistogramTb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
else
    exit 1
fi
